// ==== flist.f ====
mgmt_pkg.sv
mgmt_regs.sv
drp_port.sv
rx_frame_buffer.sv
tx_frame_buffer.sv
mgmt_top.sv
mgmt_monitor.sv
tb_mgmt_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_mgmt_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_mgmt_top.sv ====
`default_nettype none

module tb_mgmt_top;

	logic                  clk;
	logic                  rst;
	logic                  rd_en;
	logic [15:0]           rd_addr;
	logic                  rd_valid;
	logic [7:0]            rd_data;
	logic                  wr_en;
	logic [15:0]           wr_addr;
	logic [7:0]            wr_data;
	logic                  irq;
	logic                  link_up;
	mgmt_pkg::frame_byte_t rx_in;
	mgmt_pkg::frame_byte_t tx_out;
	integer                seed;

	mgmt_top UUT (
		.clk(clk), .rst(rst),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.irq(irq), .link_up(link_up), .rx_in(rx_in), .tx_out(tx_out)
	);

	mgmt_monitor mon (
		.clk(clk), .rst(rst),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.irq(irq), .rx_in(rx_in), .tx_out(tx_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Host bus

	task automatic host_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk);
		wr_en   <= 1'b1;
		wr_addr <= a;
		wr_data <= d;
		@(posedge clk);
		wr_en   <= 1'b0;
	endtask

	task automatic host_read(input logic [15:0] a, output logic [7:0] d);
		int n;
		@(posedge clk);
		rd_en   <= 1'b1;
		rd_addr <= a;
		@(posedge clk);
		rd_en   <= 1'b0;
		n = 0;
		while (!rd_valid && n < 8) begin
			@(posedge clk);
			n++;
		end
		if (!rd_valid)
			mon.fail_note("timeout waiting for rd_valid");
		d = rd_data;
	endtask

	// One frame on rx_in, a byte per cycle
	task automatic send_frame(input int len);
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			rx_in <= '{valid: 1'b1, last: (i == len - 1), data: 8'($random(seed))};
		end
		@(posedge clk);
		rx_in <= '0;
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (!irq && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (!irq)
			mon.fail_note("timeout waiting for irq with a frame queued");
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [7:0]  v;
		logic [7:0]  lo;
		logic [15:0] wd;
		logic [15:0] ad;
		logic [15:0] rd;
		logic [15:0] st;
		logic [15:0] dw;
		logic [8:0]  da;
		logic        we;
		int          n;
		int          len;
		int          nf;

		seed    = 57005;
		rst     = 1'b1;
		rd_en   = 1'b0;
		rd_addr = 16'h0000;
		wr_en   = 1'b0;
		wr_addr = 16'h0000;
		wr_data = 8'h00;
		link_up = 1'b0;
		rx_in   = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		repeat (mgmt_pkg::RSTDONE_DELAY + 1) @(posedge clk);

		// DRP writes and read-backs, small address range so words get reused
		for (int i = 0; i < 24; i++) begin
			if ($random(seed) & 1) begin
				wd = mgmt_pkg::REG_LANE1_WD;
				ad = mgmt_pkg::REG_LANE1_AD;
				rd = mgmt_pkg::REG_LANE1_RD;
				st = mgmt_pkg::REG_LANE1_STAT;
			end else begin
				wd = mgmt_pkg::REG_LANE0_WD;
				ad = mgmt_pkg::REG_LANE0_AD;
				rd = mgmt_pkg::REG_LANE0_RD;
				st = mgmt_pkg::REG_LANE0_STAT;
			end
			dw = 16'($random(seed));
			da = 9'($random(seed)) & 9'h10f;
			we = 1'($random(seed));
			host_write(wd, dw[7:0]);
			host_write(wd + 16'd1, dw[15:8]);
			host_write(ad, da[7:0]);
			host_write(ad + 16'd1, {we, 6'b0, da[8]});
			host_read(st, v);
			mon.check_value(v & 8'h03, 8'h03, "STAT right after launch");
			n = 0;
			while (v[0] && n < 20) begin
				host_read(st, v);
				n++;
			end
			if (v[0])
				mon.fail_note("DRP busy never cleared");
			host_read(rd, v);
			host_read(rd + 16'd1, v);
		end
		mon.end_test("drp access");

		// Frames of 1 to 60 bytes, one or two queued at a time
		for (int f = 0; f < 8; f++) begin
			nf = 1 + int'({$random(seed)} % 2);
			for (int k = 0; k < nf; k++) begin
				len = 1 + int'({$random(seed)} % 60);
				send_frame(len);
			end
			for (int k = 0; k < nf; k++) begin
				wait_irq();
				host_read(mgmt_pkg::REG_IRQSTAT, v);
				host_read(mgmt_pkg::REG_RXLEN, lo);
				host_read(mgmt_pkg::REG_RXLEN_1, v);
				n = int'({v[2:0], lo});
				for (int j = 0; j < (n + 3) / 4 * 4; j++)
					host_read(mgmt_pkg::REG_BUFFER_LO + 16'(j), v);
			end
		end
		mon.end_test("receive frames");

		// Length 0 makes an empty commit
		for (int f = 0; f < 8; f++) begin
			len = int'({$random(seed)} % 20);
			for (int j = 0; j < len; j++)
				host_write(mgmt_pkg::REG_BUFFER_LO + 16'(j), 8'($random(seed)));
			host_write(mgmt_pkg::REG_COMMIT, 8'h00);
		end
		// Second commit in a row has nothing to send
		host_write(mgmt_pkg::REG_COMMIT, 8'h00);
		n = 0;
		while (mon.tx_pending() != 0 && n < 500) begin
			@(posedge clk);
			n++;
		end
		if (mon.tx_pending() != 0)
			mon.fail_note("timeout waiting for committed bytes on tx_out");
		repeat (4) @(posedge clk);
		mon.end_test("transmit frames");

		for (int k = 0; k < 3; k++) begin
			@(posedge clk);
			link_up <= ~link_up;
			n = 0;
			host_read(mgmt_pkg::REG_LINK_STAT, v);
			while (v[0] != link_up && n < 10) begin
				host_read(mgmt_pkg::REG_LINK_STAT, v);
				n++;
			end
			mon.check_value(v, {7'b0, link_up}, "LINK_STAT after toggle");
		end
		mon.end_test("link status");

		// Holes in the map and write-only registers read 0
		host_read(16'h0000, v);
		host_read(16'h0050, v);
		host_read(16'h0fff, v);
		host_read(mgmt_pkg::REG_LANE0_WD, v);
		host_read(mgmt_pkg::REG_IRQSTAT_1, v);
		host_read(mgmt_pkg::REG_IRQSTAT, v);
		mon.check_value({7'b0, irq}, 8'h00, "irq after IRQSTAT read with empty queue");
		mon.end_test("unmapped and irq clear");

		mon.report();
		if (mon.err_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mgmt_monitor.sv ====
`default_nettype none

module mgmt_monitor (
	input wire                        clk,
	input wire                        rst,
	input wire                        rd_en,
	input wire [15:0]                 rd_addr,
	input wire                        rd_valid,
	input wire [7:0]                  rd_data,
	input wire                        wr_en,
	input wire [15:0]                 wr_addr,
	input wire [7:0]                  wr_data,
	input wire                        irq,
	input wire mgmt_pkg::frame_byte_t rx_in,
	input wire mgmt_pkg::frame_byte_t tx_out
);

	// Model of both DRP spaces and the shared request registers
	logic [15:0] drp_mem [2][512];
	logic [15:0] wd;
	logic [7:0]  ad_lo;
	logic [15:0] exp_rd [2];
	// Receive side: bytes of the open frame, then queued bytes with pad
	logic [7:0]  rx_cur [$];
	logic [7:0]  rx_bytes [$];
	int          rx_lens [$];
	// Header seen by the DUT queue, and the irq level it leads to
	logic        hdr_vis;
	logic        irq_exp;
	// Transmit side: open frame, then {last, data} awaiting tx_out
	logic [7:0]  tx_cur [$];
	logic [8:0]  tx_q [$];
	logic [8:0]  tx_exp;
	// Read in flight
	logic        pend_chk;
	logic [7:0]  pend_exp;
	logic [15:0] pend_addr;
	int          err_cnt;
	int          test_err;
	int          test_cnt;

	initial begin
		for (int l = 0; l < 2; l++) begin
			for (int a = 0; a < 512; a++)
				drp_mem[l][a] = 16'h0000;
			exp_rd[l] = 16'h0000;
		end
		wd       = 16'h0000;
		ad_lo    = 8'h00;
		hdr_vis  = 1'b0;
		irq_exp  = 1'b0;
		tx_exp   = 9'h000;
		pend_chk = 1'b0;
		pend_exp = 8'h00;
		pend_addr = 16'h0000;
		err_cnt  = 0;
		test_err = 0;
		test_cnt = 0;
	end

	//////////////////////////////////////////////////
	// Reporting

	task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string msg);
		if (got !== exp) begin
			$display("error %0t: %s, got %h expected %h", $time, msg, got, exp);
			err_cnt++;
			test_err++;
		end
	endtask

	task automatic fail_note(input string msg);
		$display("%s at time %0t", msg, $time);
		err_cnt++;
		test_err++;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		$display("test %0d %s finished with %0d errors", test_cnt, name, test_err);
		test_err = 0;
	endtask

	task automatic report();
		$display("%0d tests run, %0d errors in total", test_cnt, err_cnt);
	endtask

	function automatic int tx_pending();
		return tx_q.size();
	endfunction

	//////////////////////////////////////////////////
	// Expected read data from the register map

	task automatic predict_read(input logic [15:0] a, output logic chk, output logic [7:0] exp);
		int n;
		chk = 1'b1;
		exp = 8'h00;
		if (a >= mgmt_pkg::REG_BUFFER_LO) begin
			if (rx_bytes.size() == 0) begin
				fail_note("buffer read with no frame data queued");
				chk = 1'b0;
			end else
				exp = rx_bytes.pop_front();
		end else if (a == mgmt_pkg::REG_IRQSTAT)
			exp = {7'b0, rx_lens.size() != 0};
		else if (a == mgmt_pkg::REG_RXLEN || a == mgmt_pkg::REG_RXLEN_1) begin
			n = (rx_lens.size() != 0) ? rx_lens[0] : 0;
			exp = (a == mgmt_pkg::REG_RXLEN) ? n[7:0] : n[15:8];
			// High byte read takes the header off the queue
			if (a == mgmt_pkg::REG_RXLEN_1 && rx_lens.size() != 0)
				rx_lens.pop_front();
		end else if (a == mgmt_pkg::REG_LANE0_RD)
			exp = exp_rd[0][7:0];
		else if (a == mgmt_pkg::REG_LANE0_RD + 16'd1)
			exp = exp_rd[0][15:8];
		else if (a == mgmt_pkg::REG_LANE1_RD)
			exp = exp_rd[1][7:0];
		else if (a == mgmt_pkg::REG_LANE1_RD + 16'd1)
			exp = exp_rd[1][15:8];
		else if (a == mgmt_pkg::REG_LANE0_STAT || a == mgmt_pkg::REG_LANE1_STAT ||
				a == mgmt_pkg::REG_LINK_STAT)
			// Time dependent, polled by the test sequence
			chk = 1'b0;
	endtask

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		logic [8:0] da;
		int         l;
		if (a >= mgmt_pkg::REG_BUFFER_LO)
			tx_cur.push_back(d);
		else if (a == mgmt_pkg::REG_COMMIT) begin
			// Empty commit sends nothing
			while (tx_cur.size() != 0)
				tx_q.push_back({tx_cur.size() == 1, tx_cur.pop_front()});
		end else if (a == mgmt_pkg::REG_LANE0_WD || a == mgmt_pkg::REG_LANE1_WD)
			wd[7:0] = d;
		else if (a == mgmt_pkg::REG_LANE0_WD + 16'd1 || a == mgmt_pkg::REG_LANE1_WD + 16'd1)
			wd[15:8] = d;
		else if (a == mgmt_pkg::REG_LANE0_AD || a == mgmt_pkg::REG_LANE1_AD)
			ad_lo = d;
		else if (a == mgmt_pkg::REG_LANE0_AD + 16'd1 || a == mgmt_pkg::REG_LANE1_AD + 16'd1) begin
			l  = (a == mgmt_pkg::REG_LANE1_AD + 16'd1) ? 1 : 0;
			da = {d[0], ad_lo};
			// Access returns the word as it was before a write
			exp_rd[l] = drp_mem[l][da];
			if (d[7])
				drp_mem[l][da] = wd;
		end
	endtask

	//////////////////////////////////////////////////
	// Sampling, all values settled since the last edge

	always @(posedge clk) begin
		if (!rst) begin
			check_value({7'b0, irq}, {7'b0, irq_exp}, "irq level");
			// Status read clears irq, a visible header sets it
			if (rd_en && rd_addr == mgmt_pkg::REG_IRQSTAT)
				irq_exp = 1'b0;
			else if (hdr_vis)
				irq_exp = 1'b1;
			if (pend_chk && !rd_valid)
				fail_note("read response missing one cycle after the request");
			else if (pend_chk)
				check_value(rd_data, pend_exp, $sformatf("read of address %h", pend_addr));
			pend_chk = 1'b0;
			if (rd_en) begin
				pend_addr = rd_addr;
				predict_read(rd_addr, pend_chk, pend_exp);
			end
			if (wr_en)
				model_write(wr_addr, wr_data);
			if (rx_in.valid) begin
				rx_cur.push_back(rx_in.data);
				if (rx_in.last) begin
					rx_lens.push_back(rx_cur.size());
					while (rx_cur.size() != 0)
						rx_bytes.push_back(rx_cur.pop_front());
					// Final word is zero padded
					while (rx_bytes.size() % 4 != 0)
						rx_bytes.push_back(8'h00);
				end
			end
			// Header of a frame ending now reaches the DUT queue a cycle later
			hdr_vis = (rx_lens.size() - int'(rx_in.valid && rx_in.last)) != 0;
			if (tx_out.valid) begin
				if (tx_q.size() == 0)
					fail_note("tx_out produced a byte that was never committed");
				else begin
					tx_exp = tx_q.pop_front();
					check_value(tx_out.data, tx_exp[7:0], "tx_out byte");
					check_value({7'b0, tx_out.last}, {7'b0, tx_exp[8]}, "tx_out last flag");
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== mgmt_top.sv ====
`default_nettype none

module mgmt_top (
	input wire                        clk,
	input wire                        rst,
	input wire                        rd_en,
	input wire [15:0]                 rd_addr,
	output logic                      rd_valid,
	output logic [7:0]                rd_data,
	input wire                        wr_en,
	input wire [15:0]                 wr_addr,
	input wire [7:0]                  wr_data,
	output logic                      irq,
	input wire                        link_up,
	input wire mgmt_pkg::frame_byte_t rx_in,
	output mgmt_pkg::frame_byte_t     tx_out
);

	// DRP request fans out to both lanes
	mgmt_pkg::drp_req_t               drp_req;
	mgmt_pkg::drp_rsp_t               lane0_rsp;
	mgmt_pkg::drp_rsp_t               lane1_rsp;
	logic                             lane0_en;
	logic                             lane1_en;
	// Receive side
	logic [31:0]                      rx_word;
	logic [mgmt_pkg::RX_LEN_BITS-1:0] rx_len;
	logic                             rx_hdr_empty;
	logic                             rx_word_pop;
	logic                             rx_hdr_pop;
	// Transmit side
	logic                             tx_wr_en;
	logic [7:0]                       tx_wr_data;
	logic                             tx_commit;

	mgmt_regs regs (
		.clk(clk), .rst(rst),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.irq(irq), .link_up(link_up),
		.lane0_en(lane0_en), .lane1_en(lane1_en), .drp_req(drp_req),
		.lane0_rsp(lane0_rsp), .lane1_rsp(lane1_rsp),
		.rx_word(rx_word), .rx_len(rx_len), .rx_hdr_empty(rx_hdr_empty),
		.rx_word_pop(rx_word_pop), .rx_hdr_pop(rx_hdr_pop),
		.tx_wr_en(tx_wr_en), .tx_wr_data(tx_wr_data), .tx_commit(tx_commit)
	);

	drp_port lane0 (.clk(clk), .rst(rst), .en(lane0_en), .req(drp_req), .rsp(lane0_rsp));
	drp_port lane1 (.clk(clk), .rst(rst), .en(lane1_en), .req(drp_req), .rsp(lane1_rsp));

	rx_frame_buffer rx_buf (
		.clk(clk), .rst(rst), .rx_in(rx_in),
		.rx_word(rx_word), .rx_len(rx_len), .rx_hdr_empty(rx_hdr_empty),
		.rx_word_pop(rx_word_pop), .rx_hdr_pop(rx_hdr_pop)
	);

	tx_frame_buffer tx_buf (
		.clk(clk), .rst(rst), .wr_en(tx_wr_en), .wr_data(tx_wr_data),
		.commit(tx_commit), .tx_out(tx_out)
	);

endmodule

`default_nettype wire

// ==== tx_frame_buffer.sv ====
`default_nettype none

module tx_frame_buffer (
	input wire                    clk,
	input wire                    rst,
	input wire                    wr_en,
	input wire [7:0]              wr_data,
	input wire                    commit,
	output mgmt_pkg::frame_byte_t tx_out
);

	localparam int PW = mgmt_pkg::TX_PTR_BITS;
	localparam int LW = mgmt_pkg::TX_LEN_PTR_BITS;

	logic [7:0]    data_mem [mgmt_pkg::TX_DEPTH];
	// Committed frame lengths
	logic [PW-1:0] len_mem [mgmt_pkg::TX_LEN_DEPTH];
	// Base pointer is where the open frame started
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] base_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] remain;
	logic [PW-1:0] frame_len;
	logic [PW-1:0] head_len;
	logic [LW-1:0] len_wr;
	logic [LW-1:0] len_rd;
	logic          data_full;
	logic          len_full;
	logic          len_empty;
	logic          push;

	assign data_full = (wr_ptr[PW-1] != rd_ptr[PW-1]) && (wr_ptr[PW-2:0] == rd_ptr[PW-2:0]);
	assign len_full  = (len_wr[LW-1] != len_rd[LW-1]) && (len_wr[LW-2:0] == len_rd[LW-2:0]);
	assign len_empty = len_wr == len_rd;
	assign frame_len = wr_ptr - base_ptr;
	assign head_len  = len_mem[len_rd[LW-2:0]];
	// Empty commits are ignored
	assign push      = commit && (frame_len != '0) && !len_full;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr   <= '0;
			base_ptr <= '0;
			rd_ptr   <= '0;
			remain   <= '0;
			len_wr   <= '0;
			len_rd   <= '0;
			tx_out   <= '0;
		end else begin
			if (wr_en && !data_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (push) begin
				len_wr   <= len_wr + 1'b1;
				base_ptr <= wr_ptr;
			end else if (commit && len_full)
				// No room for another length, lose the frame
				wr_ptr <= base_ptr;

			//////////////////////////////////////////////////
			// Reader, one byte per cycle
			tx_out.valid <= 1'b0;
			tx_out.last  <= 1'b0;
			if (remain != '0) begin
				tx_out.valid <= 1'b1;
				tx_out.last  <= remain == 'd1;
				tx_out.data  <= data_mem[rd_ptr[PW-2:0]];
				rd_ptr       <= rd_ptr + 1'b1;
				remain       <= remain - 1'b1;
			end else if (!len_empty) begin
				// Next frame starts right behind the previous last
				tx_out.valid <= 1'b1;
				tx_out.last  <= head_len == 'd1;
				tx_out.data  <= data_mem[rd_ptr[PW-2:0]];
				rd_ptr       <= rd_ptr + 1'b1;
				remain       <= head_len - 1'b1;
				len_rd       <= len_rd + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && !data_full)
			data_mem[wr_ptr[PW-2:0]] <= wr_data;
		if (push)
			len_mem[len_wr[LW-2:0]] <= frame_len;
	end

endmodule

`default_nettype wire

// ==== rx_frame_buffer.sv ====
`default_nettype none

module rx_frame_buffer (
	input wire                              clk,
	input wire                              rst,
	input wire mgmt_pkg::frame_byte_t       rx_in,
	output logic [31:0]                     rx_word,
	output logic [mgmt_pkg::RX_LEN_BITS-1:0] rx_len,
	output logic                            rx_hdr_empty,
	input wire                              rx_word_pop,
	input wire                              rx_hdr_pop
);

	localparam int PW = mgmt_pkg::RX_PTR_BITS;
	localparam int HW = mgmt_pkg::RX_HDR_PTR_BITS;

	mgmt_pkg::frame_byte_t            in_q;
	logic [31:0]                      data_mem [mgmt_pkg::RX_DATA_DEPTH];
	logic [mgmt_pkg::RX_LEN_BITS-1:0] hdr_mem [mgmt_pkg::RX_HDR_DEPTH];
	// Write pointer runs ahead, commit pointer marks the last whole frame
	logic [PW-1:0]                    wr_ptr;
	logic [PW-1:0]                    cm_ptr;
	logic [PW-1:0]                    rd_ptr;
	logic [HW-1:0]                    hdr_wr;
	logic [HW-1:0]                    hdr_rd;
	logic [mgmt_pkg::RX_LEN_BITS-1:0] len_cnt;
	logic [31:0]                      acc;
	logic [31:0]                      word_next;
	logic                             drop;
	logic                             data_full;
	logic                             hdr_full;
	logic                             word_done;
	logic                             overflow;
	logic                             accept;

	assign data_full = (wr_ptr[PW-1] != rd_ptr[PW-1]) && (wr_ptr[PW-2:0] == rd_ptr[PW-2:0]);
	assign hdr_full  = (hdr_wr[HW-1] != hdr_rd[HW-1]) && (hdr_wr[HW-2:0] == hdr_rd[HW-2:0]);

	// Word closes on its 4th byte or at end of frame
	assign word_done = in_q.last || (len_cnt[1:0] == 2'd3);
	assign overflow  = (word_done && data_full) || (in_q.last && hdr_full);
	assign accept    = in_q.valid && !drop && !overflow;
	// Big-endian packing, unfilled bytes stay zero
	assign word_next = acc | ({in_q.data, 24'h000000} >> {len_cnt[1:0], 3'b000});

	// First-word-fall-through heads
	assign rx_word      = data_mem[rd_ptr[PW-2:0]];
	assign rx_len       = hdr_mem[hdr_rd[HW-2:0]];
	assign rx_hdr_empty = hdr_wr == hdr_rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_q    <= '0;
			wr_ptr  <= '0;
			cm_ptr  <= '0;
			rd_ptr  <= '0;
			hdr_wr  <= '0;
			hdr_rd  <= '0;
			len_cnt <= '0;
			acc     <= '0;
			drop    <= 1'b0;
		end else begin
			// Input stage
			in_q <= rx_in;
			if (in_q.valid && !accept) begin
				// Throw the frame away, back to the last commit
				wr_ptr  <= cm_ptr;
				acc     <= '0;
				len_cnt <= '0;
				drop    <= !in_q.last;
			end else if (accept) begin
				len_cnt <= len_cnt + 1'b1;
				acc     <= word_done ? 32'h0 : word_next;
				if (word_done)
					wr_ptr <= wr_ptr + 1'b1;
				if (in_q.last) begin
					cm_ptr  <= wr_ptr + 1'b1;
					hdr_wr  <= hdr_wr + 1'b1;
					len_cnt <= '0;
				end
			end
			// Only committed words and queued headers can leave
			if (rx_word_pop && (rd_ptr != cm_ptr))
				rd_ptr <= rd_ptr + 1'b1;
			if (rx_hdr_pop && !rx_hdr_empty)
				hdr_rd <= hdr_rd + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (accept && word_done)
			data_mem[wr_ptr[PW-2:0]] <= word_next;
		if (accept && in_q.last)
			hdr_mem[hdr_wr[HW-2:0]] <= len_cnt + 1'b1;
	end

endmodule

`default_nettype wire

// ==== drp_port.sv ====
`default_nettype none

module drp_port (
	input wire                     clk,
	input wire                     rst,
	input wire                     en,
	input wire mgmt_pkg::drp_req_t req,
	output mgmt_pkg::drp_rsp_t     rsp
);

	// Behavioral transceiver config space
	logic [mgmt_pkg::DRP_DATA_BITS-1:0] mem [2**mgmt_pkg::DRP_ADDR_BITS];
	// Access pipeline, data rides along with its valid
	logic [mgmt_pkg::DRP_LATENCY-2:0]                               vld_sh;
	logic [mgmt_pkg::DRP_LATENCY-2:0][mgmt_pkg::DRP_DATA_BITS-1:0] dat_sh;
	logic [mgmt_pkg::DRP_DATA_BITS-1:0] rdata_q;
	logic                               done_q;
	// Fills with ones after reset, top bit is rx reset done
	logic [mgmt_pkg::RSTDONE_DELAY-1:0] rst_sh;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**mgmt_pkg::DRP_ADDR_BITS; i++)
				mem[i] <= '0;
			vld_sh  <= '0;
			done_q  <= 1'b0;
			rdata_q <= '0;
			rst_sh  <= '0;
		end else begin
			// Write lands after the old word is sampled
			if (en && req.we)
				mem[req.addr] <= req.wdata;
			vld_sh[0] <= en;
			for (int i = 1; i < mgmt_pkg::DRP_LATENCY - 1; i++)
				vld_sh[i] <= vld_sh[i-1];
			// Done and read data show up together
			done_q <= vld_sh[mgmt_pkg::DRP_LATENCY-2];
			if (vld_sh[mgmt_pkg::DRP_LATENCY-2])
				rdata_q <= dat_sh[mgmt_pkg::DRP_LATENCY-2];
			rst_sh <= {rst_sh[mgmt_pkg::RSTDONE_DELAY-2:0], 1'b1};
		end
	end

	// Read data pipe
	always_ff @(posedge clk) begin
		dat_sh[0] <= mem[req.addr];
		for (int i = 1; i < mgmt_pkg::DRP_LATENCY - 1; i++)
			dat_sh[i] <= dat_sh[i-1];
	end

	assign rsp = '{rdata: rdata_q, done: done_q, rst_done: rst_sh[mgmt_pkg::RSTDONE_DELAY-1]};

endmodule

`default_nettype wire

// ==== mgmt_regs.sv ====
`default_nettype none

module mgmt_regs (
	input wire                                  clk,
	input wire                                  rst,
	input wire                                  rd_en,
	input wire [15:0]                           rd_addr,
	output logic                                rd_valid,
	output logic [7:0]                          rd_data,
	input wire                                  wr_en,
	input wire [15:0]                           wr_addr,
	input wire [7:0]                            wr_data,
	output logic                                irq,
	input wire                                  link_up,
	output logic                                lane0_en,
	output logic                                lane1_en,
	output mgmt_pkg::drp_req_t                  drp_req,
	input wire mgmt_pkg::drp_rsp_t              lane0_rsp,
	input wire mgmt_pkg::drp_rsp_t              lane1_rsp,
	input wire [31:0]                           rx_word,
	input wire [mgmt_pkg::RX_LEN_BITS-1:0]      rx_len,
	input wire                                  rx_hdr_empty,
	output logic                                rx_word_pop,
	output logic                                rx_hdr_pop,
	output logic                                tx_wr_en,
	output logic [7:0]                          tx_wr_data,
	output logic                                tx_commit
);

	// Link status synchronizer, oldest stage at bit 2
	logic [2:0]  link_sync;
	// Per-lane DRP access in flight
	logic [1:0]  busy;
	logic [15:0] rx_len_ext;
	logic        rd_buf;
	logic        wr_buf;
	logic [7:0]  rd_next;

	assign rd_buf     = rd_addr >= mgmt_pkg::REG_BUFFER_LO;
	assign wr_buf     = wr_addr >= mgmt_pkg::REG_BUFFER_LO;
	assign rx_len_ext = 16'(rx_len);

	//////////////////////////////////////////////////
	// Frame buffer strobes

	// Last byte of a word pops it, head moves in time for the next read
	assign rx_word_pop = rd_en && rd_buf && (rd_addr[1:0] == 2'd3);
	// High length byte is the last thing read from a header
	assign rx_hdr_pop  = rd_en && (rd_addr == mgmt_pkg::REG_RXLEN_1);
	assign tx_wr_en    = wr_en && wr_buf;
	assign tx_wr_data  = wr_data;
	assign tx_commit   = wr_en && (wr_addr == mgmt_pkg::REG_COMMIT);

	//////////////////////////////////////////////////
	// Read mux

	always_comb begin
		rd_next = 8'h00;
		if (rd_buf) begin
			// Frame bytes go out in wire order, MSB first
			case (rd_addr[1:0])
				2'd0: rd_next = rx_word[31:24];
				2'd1: rd_next = rx_word[23:16];
				2'd2: rd_next = rx_word[15:8];
				default: rd_next = rx_word[7:0];
			endcase
		end else begin
			case (rd_addr)
				mgmt_pkg::REG_IRQSTAT:            rd_next = {7'b0, !rx_hdr_empty};
				mgmt_pkg::REG_RXLEN:              rd_next = rx_len_ext[7:0];
				mgmt_pkg::REG_RXLEN_1:            rd_next = rx_len_ext[15:8];
				mgmt_pkg::REG_LINK_STAT:          rd_next = {7'b0, link_sync[2]};
				mgmt_pkg::REG_LANE0_RD:           rd_next = lane0_rsp.rdata[7:0];
				mgmt_pkg::REG_LANE0_RD + 16'd1:   rd_next = lane0_rsp.rdata[15:8];
				mgmt_pkg::REG_LANE0_STAT:         rd_next = {6'b0, lane0_rsp.rst_done, busy[0]};
				mgmt_pkg::REG_LANE1_RD:           rd_next = lane1_rsp.rdata[7:0];
				mgmt_pkg::REG_LANE1_RD + 16'd1:   rd_next = lane1_rsp.rdata[15:8];
				mgmt_pkg::REG_LANE1_STAT:         rd_next = {6'b0, lane1_rsp.rst_done, busy[1]};
				// Unmapped space reads as zero
				default:                          rd_next = 8'h00;
			endcase
		end
	end

	// Read data register, qualified by rd_valid
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= rd_next;
	end

	//////////////////////////////////////////////////
	// Control state and write decode

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid  <= 1'b0;
			irq       <= 1'b0;
			lane0_en  <= 1'b0;
			lane1_en  <= 1'b0;
			busy      <= 2'b00;
			link_sync <= 3'b000;
			drp_req   <= '0;
		end else begin
			rd_valid  <= rd_en;
			lane0_en  <= 1'b0;
			lane1_en  <= 1'b0;
			link_sync <= {link_sync[1:0], link_up};

			// Frame waiting raises irq, status read drops it
			if (!rx_hdr_empty)
				irq <= 1'b1;
			if (rd_en && (rd_addr == mgmt_pkg::REG_IRQSTAT))
				irq <= 1'b0;

			// Busy from the cycle after the enable through done
			if (lane0_en)
				busy[0] <= 1'b1;
			if (lane0_rsp.done)
				busy[0] <= 1'b0;
			if (lane1_en)
				busy[1] <= 1'b1;
			if (lane1_rsp.done)
				busy[1] <= 1'b0;

			// Both lanes share one request, enables pick the lane
			if (wr_en) begin
				case (wr_addr)
					mgmt_pkg::REG_LANE0_WD,
					mgmt_pkg::REG_LANE1_WD:
						drp_req.wdata[7:0] <= wr_data;
					mgmt_pkg::REG_LANE0_WD + 16'd1,
					mgmt_pkg::REG_LANE1_WD + 16'd1:
						drp_req.wdata[15:8] <= wr_data;
					mgmt_pkg::REG_LANE0_AD,
					mgmt_pkg::REG_LANE1_AD:
						drp_req.addr[7:0] <= wr_data;
					// High address byte launches the access
					mgmt_pkg::REG_LANE0_AD + 16'd1: begin
						lane0_en <= 1'b1;
						drp_req.we <= wr_data[7];
						drp_req.addr[mgmt_pkg::DRP_ADDR_BITS-1] <= wr_data[0];
					end
					mgmt_pkg::REG_LANE1_AD + 16'd1: begin
						lane1_en <= 1'b1;
						drp_req.we <= wr_data[7];
						drp_req.addr[mgmt_pkg::DRP_ADDR_BITS-1] <= wr_data[0];
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== mgmt_pkg.sv ====
`default_nettype none

package mgmt_pkg;

	//////////////////////////////////////////////////
	// Register map

	// Interrupt status, bit 0 = rx frame ready
	localparam logic [15:0] REG_IRQSTAT     = 16'h0020;
	localparam logic [15:0] REG_IRQSTAT_1   = 16'h0021;
	// Length of frame at head of rx queue
	localparam logic [15:0] REG_RXLEN       = 16'h0024;
	localparam logic [15:0] REG_RXLEN_1     = 16'h0025;
	// Any write ends the tx frame being built
	localparam logic [15:0] REG_COMMIT      = 16'h0028;
	localparam logic [15:0] REG_LINK_STAT   = 16'h0060;

	// DRP registers, low byte at base, high byte at base+1
	// AD high byte: bit 7 = write enable, bit 0 = addr[8]
	localparam logic [15:0] REG_LANE0_WD    = 16'h0084;
	localparam logic [15:0] REG_LANE0_AD    = 16'h0086;
	localparam logic [15:0] REG_LANE0_RD    = 16'h0088;
	// STAT: bit 0 = busy, bit 1 = rx reset done
	localparam logic [15:0] REG_LANE0_STAT  = 16'h008a;
	localparam logic [15:0] REG_LANE1_WD    = 16'h00a4;
	localparam logic [15:0] REG_LANE1_AD    = 16'h00a6;
	localparam logic [15:0] REG_LANE1_RD    = 16'h00a8;
	localparam logic [15:0] REG_LANE1_STAT  = 16'h00aa;

	// Frame buffer window, everything from here up
	localparam logic [15:0] REG_BUFFER_LO   = 16'h1000;

	//////////////////////////////////////////////////
	// Sizes and latencies

	localparam int DRP_ADDR_BITS   = 9;
	localparam int DRP_DATA_BITS   = 16;
	localparam int DRP_LATENCY     = 4;
	localparam int RSTDONE_DELAY   = 20;
	localparam int RX_LEN_BITS     = 11;
	localparam int RX_DATA_DEPTH   = 512;
	localparam int RX_HDR_DEPTH    = 4;
	localparam int TX_DEPTH        = 2048;
	localparam int TX_LEN_DEPTH    = 8;

	// Pointers carry one extra wrap bit
	localparam int RX_PTR_BITS     = $clog2(RX_DATA_DEPTH) + 1;
	localparam int RX_HDR_PTR_BITS = $clog2(RX_HDR_DEPTH) + 1;
	localparam int TX_PTR_BITS     = $clog2(TX_DEPTH) + 1;
	localparam int TX_LEN_PTR_BITS = $clog2(TX_LEN_DEPTH) + 1;

	//////////////////////////////////////////////////
	// Bundles

	// Request shared by both lanes
	typedef struct packed {
		logic                     we;
		logic [DRP_ADDR_BITS-1:0] addr;
		logic [DRP_DATA_BITS-1:0] wdata;
	} drp_req_t;

	typedef struct packed {
		logic [DRP_DATA_BITS-1:0] rdata;
		logic                     done;
		logic                     rst_done;
	} drp_rsp_t;

	// One byte of an Ethernet frame
	typedef struct packed {
		logic       valid;
		logic       last;
		logic [7:0] data;
	} frame_byte_t;

endpackage

`default_nettype wire
